/* hw/ooo_pkg.sv */
// widths, depths, ALU operation codes, ROB entry states and the bus structs of the core
package ooo_pkg;

	////////////////////////////////////////////////////////////////////////////
	// widths and depths
	////////////////////////////////////////////////////////////////////////////

	localparam int xlen          = 32;
	localparam int num_arch_regs = 8;
	localparam int rob_depth     = 4;
	localparam int rs_depth      = 4;

	typedef logic [xlen-1:0]                  word_t;
	typedef logic [$clog2(num_arch_regs)-1:0] reg_idx_t;
	typedef logic [$clog2(rob_depth)-1:0]     rob_tag_t;
	// occupancy needs one value more than a tag
	typedef logic [$clog2(rob_depth+1)-1:0]   rob_count_t;
	// rs slot number, also the older-entry count of a slot
	typedef logic [$clog2(rs_depth)-1:0]      rs_idx_t;
	typedef logic [2:0]                       alu_op_t;

	// alu operation codes
	localparam alu_op_t op_add  = 3'd0;
	localparam alu_op_t op_sub  = 3'd1;
	localparam alu_op_t op_and  = 3'd2;
	localparam alu_op_t op_or   = 3'd3;
	localparam alu_op_t op_xor  = 3'd4;
	localparam alu_op_t op_slt  = 3'd5;   // signed compare, 1 or 0
	localparam alu_op_t op_addi = 3'd6;   // rs1 + imm
	localparam alu_op_t op_li   = 3'd7;   // imm only

	// life of a rob slot
	typedef enum logic [1:0] {
		rob_free,
		rob_waiting,
		rob_done
	} rob_state_t;

	////////////////////////////////////////////////////////////////////////////
	// buses between the units
	////////////////////////////////////////////////////////////////////////////

	// decoded instruction from outside, 44 bits
	typedef struct packed {
		alu_op_t  op;
		reg_idx_t rd;
		reg_idx_t rs1;
		reg_idx_t rs2;
		word_t    imm;
	} inst_t;

	// one source, either a value or the tag it waits on, 35 bits
	typedef struct packed {
		logic     ready;
		rob_tag_t tag;
		word_t    value;
	} operand_t;

	// renamed instruction into rs and rob, 78 bits
	typedef struct packed {
		alu_op_t  op;
		reg_idx_t rd;
		rob_tag_t tag;
		operand_t src1;
		operand_t src2;
	} dispatch_t;

	// rs to alu, 70 bits
	typedef struct packed {
		logic     valid;
		alu_op_t  op;
		rob_tag_t tag;
		word_t    a;
		word_t    b;
	} issue_t;

	// result broadcast, 35 bits
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		word_t    value;
	} cdb_t;

	// in-order retirement, 38 bits
	typedef struct packed {
		logic     valid;
		rob_tag_t tag;
		reg_idx_t rd;
		word_t    value;
	} commit_t;

endpackage

/* hw/dispatch_rename.sv */
// dispatch stage with register file, map table, operand lookup and stall
module dispatch_rename (
	input  logic               clock,
	input  logic               reset,
	input  logic               in_valid,
	input  ooo_pkg::inst_t     in_inst,
	input  logic               rob_full,
	input  logic               rs_full,
	input  ooo_pkg::rob_tag_t  alloc_tag,
	input  ooo_pkg::operand_t  rob_src1,
	input  ooo_pkg::operand_t  rob_src2,
	input  ooo_pkg::commit_t   commit,
	output logic               stall,
	output logic               dispatch_fire,
	output ooo_pkg::dispatch_t dispatch,
	output ooo_pkg::rob_tag_t  src1_tag,
	output ooo_pkg::rob_tag_t  src2_tag
);

	// architectural state
	ooo_pkg::word_t    regs     [ooo_pkg::num_arch_regs];
	// rename state, busy means a rob slot will produce the register
	logic              map_busy [ooo_pkg::num_arch_regs];
	ooo_pkg::rob_tag_t map_tag  [ooo_pkg::num_arch_regs];

	logic              src1_imm;
	logic              src2_imm;

	// picks the source of one operand
	function automatic ooo_pkg::operand_t build_operand(
		input ooo_pkg::reg_idx_t idx,
		input logic              use_imm,
		input ooo_pkg::operand_t rob_op
	);
		ooo_pkg::operand_t opnd;
		logic              committing;
		opnd.ready = 1'b1;
		opnd.tag   = map_tag[idx];
		// producer retiring right now, its value sits on the commit bus
		committing = commit.valid && (commit.tag == map_tag[idx]);
		if (use_imm) begin
			opnd.value = in_inst.imm;
		end else if (idx == '0) begin
			opnd.value = '0;
		end else if (!map_busy[idx] || committing) begin
			// write-through of the register file
			if (commit.valid && (commit.rd == idx))
				opnd.value = commit.value;
			else
				opnd.value = regs[idx];
		end else begin
			// in flight, rob read port has it or gives the tag
			opnd = rob_op;
		end
		return opnd;
	endfunction

	// single stall level for both units
	assign stall         = rob_full || rs_full;
	assign dispatch_fire = in_valid && !stall;

	// rob lookups for busy sources
	assign src1_tag = map_tag[in_inst.rs1];
	assign src2_tag = map_tag[in_inst.rs2];

	// li takes imm on both sides, addi only on b
	assign src1_imm = (in_inst.op == ooo_pkg::op_li);
	assign src2_imm = (in_inst.op == ooo_pkg::op_addi) || (in_inst.op == ooo_pkg::op_li);

	always_comb begin
		dispatch.op   = in_inst.op;
		dispatch.rd   = in_inst.rd;
		dispatch.tag  = alloc_tag;
		dispatch.src1 = build_operand(in_inst.rs1, src1_imm, rob_src1);
		dispatch.src2 = build_operand(in_inst.rs2, src2_imm, rob_src2);
	end

	////////////////////////////////////////////////////////////////////////////
	// register file and map table update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ooo_pkg::num_arch_regs; i++) begin
				regs[i]     <= '0;
				map_busy[i] <= 1'b0;
			end
		end else begin
			// retirement, r0 stays zero
			if (commit.valid && (commit.rd != '0)) begin
				regs[commit.rd] <= commit.value;
				// only the newest producer clears busy
				if (map_busy[commit.rd] && (map_tag[commit.rd] == commit.tag) &&
				    !(dispatch_fire && (in_inst.rd == commit.rd)))
					map_busy[commit.rd] <= 1'b0;
			end
			// rename the destination
			if (dispatch_fire && (in_inst.rd != '0)) begin
				map_busy[in_inst.rd] <= 1'b1;
				map_tag[in_inst.rd]  <= alloc_tag;
			end
		end
	end

endmodule

/* hw/reservation_station.sv */
// alu reservation station with cdb wakeup and oldest-ready selection
module reservation_station (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_fire,
	input  ooo_pkg::dispatch_t dispatch,
	input  ooo_pkg::cdb_t      cdb,
	output logic               full,
	output ooo_pkg::issue_t    issue
);

	logic               entry_valid [ooo_pkg::rs_depth];
	ooo_pkg::dispatch_t entry       [ooo_pkg::rs_depth];
	// number of older valid entries, zero is the oldest
	ooo_pkg::rs_idx_t   age         [ooo_pkg::rs_depth];

	logic               free_found;
	ooo_pkg::rs_idx_t   free_idx;
	logic               pick_found;
	ooo_pkg::rs_idx_t   pick_idx;
	ooo_pkg::rs_idx_t   remaining;

	////////////////////////////////////////////////////////////////////////////
	// slot search
	////////////////////////////////////////////////////////////////////////////

	// lowest empty slot for the next dispatch
	always_comb begin
		free_found = 1'b0;
		free_idx   = '0;
		for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
			if (!entry_valid[i] && !free_found) begin
				free_found = 1'b1;
				free_idx   = ooo_pkg::rs_idx_t'(i);
			end
		end
	end

	assign full = !free_found;

	// oldest entry with both operands ready
	always_comb begin
		pick_found = 1'b0;
		pick_idx   = '0;
		for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
			if (entry_valid[i] && entry[i].src1.ready && entry[i].src2.ready) begin
				if (!pick_found || (age[i] < age[pick_idx])) begin
					pick_found = 1'b1;
					pick_idx   = ooo_pkg::rs_idx_t'(i);
				end
			end
		end
	end

	// entries left after this cycle's issue, age of a new entry
	always_comb begin
		remaining = '0;
		for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
			if (entry_valid[i] && !(pick_found && (pick_idx == ooo_pkg::rs_idx_t'(i))))
				remaining = remaining + 1'b1;
		end
	end

	always_comb begin
		issue.valid = pick_found;
		issue.op    = entry[pick_idx].op;
		issue.tag   = entry[pick_idx].tag;
		issue.a     = entry[pick_idx].src1.value;
		issue.b     = entry[pick_idx].src2.value;
	end

	////////////////////////////////////////////////////////////////////////////
	// entry update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < ooo_pkg::rs_depth; i++)
				entry_valid[i] <= 1'b0;
		end else begin
			for (int i = 0; i < ooo_pkg::rs_depth; i++) begin
				// snoop the cdb
				if (cdb.valid && entry_valid[i]) begin
					if (!entry[i].src1.ready && (entry[i].src1.tag == cdb.tag)) begin
						entry[i].src1.ready <= 1'b1;
						entry[i].src1.value <= cdb.value;
					end
					if (!entry[i].src2.ready && (entry[i].src2.tag == cdb.tag)) begin
						entry[i].src2.ready <= 1'b1;
						entry[i].src2.value <= cdb.value;
					end
				end
				// younger entries move up one
				if (pick_found && entry_valid[i] && (age[i] > age[pick_idx]))
					age[i] <= age[i] - 1'b1;
			end
			if (pick_found)
				entry_valid[pick_idx] <= 1'b0;
			if (dispatch_fire) begin
				entry_valid[free_idx] <= 1'b1;
				entry[free_idx]       <= dispatch;
				age[free_idx]         <= remaining;
			end
		end
	end

endmodule

/* hw/alu_unit.sv */
// single-cycle alu with its result register on the cdb
module alu_unit (
	input  logic            clock,
	input  logic            reset,
	input  ooo_pkg::issue_t issue,
	output ooo_pkg::cdb_t   cdb
);

	ooo_pkg::word_t result;

	always_comb begin
		case (issue.op)
			ooo_pkg::op_add:  result = issue.a + issue.b;
			ooo_pkg::op_sub:  result = issue.a - issue.b;
			ooo_pkg::op_and:  result = issue.a & issue.b;
			ooo_pkg::op_or:   result = issue.a | issue.b;
			ooo_pkg::op_xor:  result = issue.a ^ issue.b;
			// signed compare, zero extended flag
			ooo_pkg::op_slt:  result = {31'b0, $signed(issue.a) < $signed(issue.b)};
			ooo_pkg::op_addi: result = issue.a + issue.b;
			// b already holds imm
			default:          result = issue.b;
		endcase
	end

	// broadcast one cycle after issue
	always_ff @(posedge clock) begin
		cdb.tag   <= issue.tag;
		cdb.value <= result;
		if (reset)
			cdb.valid <= 1'b0;
		else
			cdb.valid <= issue.valid;
	end

endmodule

/* hw/reorder_buffer.sv */
// reorder buffer with operand read ports, cdb capture and in-order commit
module reorder_buffer (
	input  logic               clock,
	input  logic               reset,
	input  logic               dispatch_fire,
	input  ooo_pkg::dispatch_t dispatch,
	input  ooo_pkg::cdb_t      cdb,
	input  ooo_pkg::rob_tag_t  src1_tag,
	input  ooo_pkg::rob_tag_t  src2_tag,
	output ooo_pkg::rob_tag_t  alloc_tag,
	output logic               full,
	output ooo_pkg::operand_t  rob_src1,
	output ooo_pkg::operand_t  rob_src2,
	output ooo_pkg::commit_t   commit
);

	ooo_pkg::rob_state_t state      [ooo_pkg::rob_depth];
	ooo_pkg::reg_idx_t   slot_rd    [ooo_pkg::rob_depth];
	ooo_pkg::word_t      slot_value [ooo_pkg::rob_depth];

	ooo_pkg::rob_tag_t   head;
	ooo_pkg::rob_tag_t   tail;
	ooo_pkg::rob_count_t count;
	logic                head_done;

	// slot lookup, with bypass of this cycle's broadcast
	function automatic ooo_pkg::operand_t read_port(input ooo_pkg::rob_tag_t tag);
		ooo_pkg::operand_t opnd;
		opnd.tag   = tag;
		opnd.ready = 1'b0;
		opnd.value = slot_value[tag];
		if (cdb.valid && (cdb.tag == tag)) begin
			opnd.ready = 1'b1;
			opnd.value = cdb.value;
		end else if (state[tag] == ooo_pkg::rob_done) begin
			opnd.ready = 1'b1;
		end
		return opnd;
	endfunction

	assign alloc_tag = tail;
	assign full      = (count == ooo_pkg::rob_count_t'(ooo_pkg::rob_depth));
	assign head_done = (state[head] == ooo_pkg::rob_done);

	always_comb begin
		rob_src1 = read_port(src1_tag);
		rob_src2 = read_port(src2_tag);
	end

	////////////////////////////////////////////////////////////////////////////
	// allocate, complete, retire
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		// retirement payload, qualified by commit.valid
		commit.tag   <= head;
		commit.rd    <= slot_rd[head];
		commit.value <= slot_value[head];
		if (reset) begin
			head         <= '0;
			tail         <= '0;
			count        <= '0;
			commit.valid <= 1'b0;
			for (int i = 0; i < ooo_pkg::rob_depth; i++)
				state[i] <= ooo_pkg::rob_free;
		end else begin
			// new slot at the tail
			if (dispatch_fire) begin
				state[tail]   <= ooo_pkg::rob_waiting;
				slot_rd[tail] <= dispatch.rd;
				tail          <= tail + 1'b1;
			end
			// alu result arrives
			if (cdb.valid) begin
				state[cdb.tag]      <= ooo_pkg::rob_done;
				slot_value[cdb.tag] <= cdb.value;
			end
			// one retirement per cycle, program order
			if (head_done) begin
				state[head] <= ooo_pkg::rob_free;
				head        <= head + 1'b1;
			end
			commit.valid <= head_done;
			if (dispatch_fire && !head_done)
				count <= count + 1'b1;
			else if (!dispatch_fire && head_done)
				count <= count - 1'b1;
		end
	end

endmodule

/* hw/ooo_core.sv */
// top level of the out-of-order core, connects dispatch, rs, alu and rob
module ooo_core (
	input  logic             clock,
	input  logic             reset,
	input  logic             in_valid,
	input  ooo_pkg::inst_t   in_inst,
	output logic             stall,
	output ooo_pkg::commit_t commit
);

	// dispatch to rs and rob
	logic               dispatch_fire;
	ooo_pkg::dispatch_t dispatch;
	ooo_pkg::rob_tag_t  src1_tag;
	ooo_pkg::rob_tag_t  src2_tag;

	// back from the rob and rs
	ooo_pkg::rob_tag_t  alloc_tag;
	logic               rob_full;
	logic               rs_full;
	ooo_pkg::operand_t  rob_src1;
	ooo_pkg::operand_t  rob_src2;

	// execution path
	ooo_pkg::issue_t    issue;
	ooo_pkg::cdb_t      cdb;

	dispatch_rename dispatch_rename_0 (
		.clock(clock), .reset(reset),
		.in_valid(in_valid), .in_inst(in_inst),
		.rob_full(rob_full), .rs_full(rs_full), .alloc_tag(alloc_tag),
		.rob_src1(rob_src1), .rob_src2(rob_src2), .commit(commit),
		.stall(stall), .dispatch_fire(dispatch_fire), .dispatch(dispatch),
		.src1_tag(src1_tag), .src2_tag(src2_tag)
	);

	reservation_station reservation_station_0 (
		.clock(clock), .reset(reset),
		.dispatch_fire(dispatch_fire), .dispatch(dispatch), .cdb(cdb),
		.full(rs_full), .issue(issue)
	);

	alu_unit alu_unit_0 (
		.clock(clock), .reset(reset), .issue(issue), .cdb(cdb)
	);

	reorder_buffer reorder_buffer_0 (
		.clock(clock), .reset(reset),
		.dispatch_fire(dispatch_fire), .dispatch(dispatch), .cdb(cdb),
		.src1_tag(src1_tag), .src2_tag(src2_tag),
		.alloc_tag(alloc_tag), .full(rob_full),
		.rob_src1(rob_src1), .rob_src2(rob_src2), .commit(commit)
	);

endmodule

/* verification/clock_gen.sv */
// testbench clock and reset source
module clock_gen (
	output logic clock,
	output logic reset
);

	timeunit 1ns;
	timeprecision 1ps;

	// 40 ns period
	localparam int half_period = 20;

	initial begin
		clock = 1'b0;
		forever #half_period clock = ~clock;
	end

	// high over the first two rising edges
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

/* verification/ooo_core_assertions.sv */
// concurrent checks on reorder buffer occupancy and commit, with their bind
module ooo_core_assertions (
	input logic                clock,
	input logic                reset,
	input ooo_pkg::rob_count_t count,
	input logic                head_done,
	input logic                commit_valid
);

	timeunit 1ns;
	timeprecision 1ps;

	// read by the testbench top at the end of the run
	int fail_count = 0;

	// occupancy bounded by the slot count
	assert property (@(posedge clock) disable iff (reset) count <= ooo_pkg::rob_depth)
	else begin
		fail_count++;
		$error("reorder buffer count above its depth");
	end

	// every retirement comes from a done head of an occupied buffer one edge earlier
	assert property (@(posedge clock) disable iff (reset)
		commit_valid |-> $past(head_done && (count != '0)))
	else begin
		fail_count++;
		$error("commit pulsed without a done head slot in an occupied buffer");
	end

	// first cycle out of reset is quiet
	assert property (@(posedge clock) $fell(reset) |-> !commit_valid)
	else begin
		fail_count++;
		$error("commit valid right after reset");
	end

endmodule

bind reorder_buffer ooo_core_assertions rob_checks (
	.clock(clock),
	.reset(reset),
	.count(count),
	.head_done(head_done),
	.commit_valid(commit.valid)
);

/* verification/ooo_core_tb.sv */
// testbench top: stimulus table, xorshift stream, in-order model, commit checks
module ooo_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          table_size     = 28;
	localparam int          random_count   = 40;
	localparam logic [31:0] seed           = 32'd38307;
	localparam int          timeout_margin = 50;
	localparam int          timeout_cycles = (table_size + random_count) * 10 + timeout_margin;

	// one table row, instruction plus what it must retire
	typedef struct packed {
		ooo_pkg::inst_t    inst;
		ooo_pkg::reg_idx_t exp_rd;
		ooo_pkg::word_t    exp_value;
	} row_t;

	// one outstanding retirement
	typedef struct packed {
		ooo_pkg::rob_tag_t tag;
		ooo_pkg::reg_idx_t rd;
		ooo_pkg::word_t    value;
	} expect_t;

	logic             clock;
	logic             reset;
	logic             in_valid;
	ooo_pkg::inst_t   in_inst;
	logic             stall;
	ooo_pkg::commit_t commit;

	row_t             stim_rows  [table_size];
	ooo_pkg::word_t   model_regs [ooo_pkg::num_arch_regs];
	expect_t          expect_q   [$];
	expect_t          head_exp;
	logic [31:0]      rng_state;
	int               errors         = 0;
	int               accepted_count = 0;
	int               commit_count   = 0;
	int               stall_cycles   = 0;
	int               cycles         = 0;

	clock_gen clock_gen_0 (.clock(clock), .reset(reset));

	ooo_core ooo_core_i (
		.clock(clock), .reset(reset),
		.in_valid(in_valid), .in_inst(in_inst),
		.stall(stall), .commit(commit)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// result by the operation rules, on the in-order register state
	function automatic ooo_pkg::word_t model_result(input ooo_pkg::inst_t inst);
		ooo_pkg::word_t a;
		ooo_pkg::word_t b;
		ooo_pkg::word_t r;
		a = model_regs[inst.rs1];
		b = model_regs[inst.rs2];
		case (inst.op)
			ooo_pkg::op_add:  r = a + b;
			ooo_pkg::op_sub:  r = a - b;
			ooo_pkg::op_and:  r = a & b;
			ooo_pkg::op_or:   r = a | b;
			ooo_pkg::op_xor:  r = a ^ b;
			ooo_pkg::op_slt:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			ooo_pkg::op_addi: r = a + inst.imm;
			default:          r = inst.imm;
		endcase
		return r;
	endfunction

	function automatic row_t make_row(
		input ooo_pkg::alu_op_t  op,
		input ooo_pkg::reg_idx_t rd,
		input ooo_pkg::reg_idx_t rs1,
		input ooo_pkg::reg_idx_t rs2,
		input ooo_pkg::word_t    imm,
		input ooo_pkg::word_t    value
	);
		row_t row;
		row.inst.op   = op;
		row.inst.rd   = rd;
		row.inst.rs1  = rs1;
		row.inst.rs2  = rs2;
		row.inst.imm  = imm;
		row.exp_rd    = rd;
		row.exp_value = value;
		return row;
	endfunction

	task automatic load_table();
		// every operation code on two seeds
		stim_rows[0]  = make_row(ooo_pkg::op_li,   3'd1, 3'd0, 3'd0, 32'h0000_00f5, 32'h0000_00f5);
		stim_rows[1]  = make_row(ooo_pkg::op_li,   3'd2, 3'd0, 3'd0, 32'hffff_fff0, 32'hffff_fff0);
		stim_rows[2]  = make_row(ooo_pkg::op_add,  3'd3, 3'd1, 3'd2, 32'h0, 32'h0000_00e5);
		stim_rows[3]  = make_row(ooo_pkg::op_sub,  3'd4, 3'd1, 3'd2, 32'h0, 32'h0000_0105);
		stim_rows[4]  = make_row(ooo_pkg::op_and,  3'd5, 3'd1, 3'd2, 32'h0, 32'h0000_00f0);
		stim_rows[5]  = make_row(ooo_pkg::op_or,   3'd6, 3'd1, 3'd2, 32'h0, 32'hffff_fff5);
		stim_rows[6]  = make_row(ooo_pkg::op_xor,  3'd7, 3'd1, 3'd2, 32'h0, 32'hffff_ff05);
		stim_rows[7]  = make_row(ooo_pkg::op_slt,  3'd3, 3'd2, 3'd1, 32'h0, 32'h0000_0001);
		stim_rows[8]  = make_row(ooo_pkg::op_slt,  3'd4, 3'd1, 3'd2, 32'h0, 32'h0000_0000);
		stim_rows[9]  = make_row(ooo_pkg::op_addi, 3'd5, 3'd1, 3'd0, 32'hffff_ffff, 32'h0000_00f4);
		// back to back raw chain
		stim_rows[10] = make_row(ooo_pkg::op_addi, 3'd1, 3'd1, 3'd0, 32'h0000_0010, 32'h0000_0105);
		stim_rows[11] = make_row(ooo_pkg::op_add,  3'd2, 3'd1, 3'd1, 32'h0, 32'h0000_020a);
		stim_rows[12] = make_row(ooo_pkg::op_sub,  3'd3, 3'd2, 3'd1, 32'h0, 32'h0000_0105);
		stim_rows[13] = make_row(ooo_pkg::op_xor,  3'd4, 3'd3, 3'd2, 32'h0, 32'h0000_030f);
		// r6 renamed twice, reader sees the second
		stim_rows[14] = make_row(ooo_pkg::op_li,   3'd6, 3'd0, 3'd0, 32'h1111_1111, 32'h1111_1111);
		stim_rows[15] = make_row(ooo_pkg::op_li,   3'd6, 3'd0, 3'd0, 32'h2222_2222, 32'h2222_2222);
		stim_rows[16] = make_row(ooo_pkg::op_add,  3'd7, 3'd6, 3'd0, 32'h0, 32'h2222_2222);
		// write to r0 is dropped
		stim_rows[17] = make_row(ooo_pkg::op_li,   3'd0, 3'd0, 3'd0, 32'hdead_beef, 32'hdead_beef);
		stim_rows[18] = make_row(ooo_pkg::op_add,  3'd1, 3'd0, 3'd0, 32'h0, 32'h0000_0000);
		stim_rows[19] = make_row(ooo_pkg::op_addi, 3'd2, 3'd0, 3'd0, 32'h0000_0007, 32'h0000_0007);
		// serial chain, fills the rob
		stim_rows[20] = make_row(ooo_pkg::op_addi, 3'd3, 3'd2, 3'd0, 32'h0000_0001, 32'h0000_0008);
		stim_rows[21] = make_row(ooo_pkg::op_addi, 3'd3, 3'd3, 3'd0, 32'h0000_0001, 32'h0000_0009);
		stim_rows[22] = make_row(ooo_pkg::op_addi, 3'd3, 3'd3, 3'd0, 32'h0000_0001, 32'h0000_000a);
		stim_rows[23] = make_row(ooo_pkg::op_addi, 3'd3, 3'd3, 3'd0, 32'h0000_0001, 32'h0000_000b);
		stim_rows[24] = make_row(ooo_pkg::op_add,  3'd4, 3'd3, 3'd3, 32'h0, 32'h0000_0016);
		stim_rows[25] = make_row(ooo_pkg::op_sub,  3'd5, 3'd4, 3'd3, 32'h0, 32'h0000_000b);
		// r6 long retired, read from the register file
		stim_rows[26] = make_row(ooo_pkg::op_or,   3'd5, 3'd6, 3'd0, 32'h0, 32'h2222_2222);
		stim_rows[27] = make_row(ooo_pkg::op_and,  3'd7, 3'd7, 3'd6, 32'h0, 32'h2222_2222);
	endtask

	// holds the instruction until a rising edge with stall low takes it
	task automatic drive_inst(
		input ooo_pkg::inst_t    inst,
		input ooo_pkg::reg_idx_t exp_rd,
		input ooo_pkg::word_t    exp_value
	);
		expect_t entry;
		// rob slots handed out in a ring from zero
		entry.tag   = ooo_pkg::rob_tag_t'(accepted_count % ooo_pkg::rob_depth);
		entry.rd    = exp_rd;
		entry.value = exp_value;
		expect_q.push_back(entry);
		in_valid <= 1'b1;
		in_inst  <= inst;
		@(negedge clock);
		while (stall) begin
			stall_cycles++;
			@(negedge clock);
		end
		@(posedge clock);
		accepted_count++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// commit monitor, sampled mid-cycle
	////////////////////////////////////////////////////////////////////////////

	always @(negedge clock) begin
		if (!reset && commit.valid) begin
			commit_count++;
			assert (expect_q.size() != 0)
			else begin
				errors++;
				$display("commit of rd %0d arrived with no instruction outstanding", commit.rd);
			end
			if (expect_q.size() != 0) begin
				head_exp = expect_q.pop_front();
				assert (commit.tag == head_exp.tag)
				else begin
					errors++;
					$display("Fail commit.tag got %h expected %h", commit.tag, head_exp.tag);
				end
				assert (commit.rd == head_exp.rd)
				else begin
					errors++;
					$display("Fail commit.rd got %h expected %h", commit.rd, head_exp.rd);
				end
				assert (commit.value == head_exp.value)
				else begin
					errors++;
					$display("Fail commit.value got %h expected %h", commit.value, head_exp.value);
				end
			end
		end
	end

	// run limit from the instruction count
	initial begin : watchdog
		while (cycles < timeout_cycles) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout after %0d cycles, %0d of %0d commits seen",
		         cycles, commit_count, accepted_count);
		$display("ERRORS FOUND");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		ooo_pkg::inst_t inst;
		ooo_pkg::word_t value;
		int             total;
		in_valid = 1'b0;
		in_inst  = '0;
		for (int r = 0; r < ooo_pkg::num_arch_regs; r++)
			model_regs[r] = '0;
		load_table();
		rng_state = seed;

		@(negedge clock);
		while (reset) @(negedge clock);
		assert (!stall)
		else begin
			errors++;
			$display("Fail stall got %h expected %h", stall, 1'b0);
		end
		@(posedge clock);

		// directed rows, model follows the table
		for (int n = 0; n < table_size; n++) begin
			if (stim_rows[n].exp_rd != '0)
				model_regs[stim_rows[n].exp_rd] = stim_rows[n].exp_value;
			drive_inst(stim_rows[n].inst, stim_rows[n].exp_rd, stim_rows[n].exp_value);
		end

		// random stream, fields from one draw and imm from the next
		for (int n = 0; n < random_count; n++) begin
			rng_state = xorshift(rng_state);
			inst.op   = rng_state[2:0];
			inst.rd   = rng_state[5:3];
			inst.rs1  = rng_state[8:6];
			inst.rs2  = rng_state[11:9];
			rng_state = xorshift(rng_state);
			inst.imm  = rng_state;
			value     = model_result(inst);
			if (inst.rd != '0)
				model_regs[inst.rd] = value;
			drive_inst(inst, inst.rd, value);
		end
		in_valid <= 1'b0;

		// drain, then a few idle cycles to catch extra commits
		while (commit_count < accepted_count) @(posedge clock);
		repeat (8) @(posedge clock);

		assert (commit_count == accepted_count)
		else begin
			errors++;
			$display("commit count %0d does not match accepted count %0d",
			         commit_count, accepted_count);
		end
		assert (expect_q.size() == 0)
		else begin
			errors++;
			$display("%0d expected commits never arrived", expect_q.size());
		end
		assert (stall_cycles > 0)
		else begin
			errors++;
			$display("stall never rose during the dependency chain");
		end

		total = errors + ooo_core_i.reorder_buffer_0.rob_checks.fail_count;
		$display("%0d errors (%0d checks, %0d assertions), %0d accepted, %0d committed, %0d stalled",
		         total, errors, ooo_core_i.reorder_buffer_0.rob_checks.fail_count,
		         accepted_count, commit_count, stall_cycles);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* sources.f */
hw/ooo_pkg.sv
hw/dispatch_rename.sv
hw/reservation_station.sv
hw/alu_unit.sv
hw/reorder_buffer.sv
hw/ooo_core.sv
verification/clock_gen.sv
verification/ooo_core_assertions.sv
verification/ooo_core_tb.sv

/* Makefile */
# Verilator build and run of the out-of-order core testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ooo_core_tb -f sources.f
	./obj_dir/Vooo_core_tb +verilator+error+limit+100 > $(LOG) 2>&1; cat $(LOG)
	grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
